// File: src/cpu_types_pkg.sv
package cpu_types_pkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////
  localparam int WORD_W      = 16;                // One data word or one PC value
  localparam int REG_ADDR_W  = 4;                 // Register number width
  localparam int NUM_REGS    = 1 << REG_ADDR_W;   // Sixteen general purpose registers

  // Only the low address bits reach the data memory array
  localparam int DMEM_ADDR_W = 8;
  localparam int DMEM_DEPTH  = 1 << DMEM_ADDR_W;  // 256 words

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////
  typedef logic [WORD_W-1:0]      word_t;        // Data word, ALU result or PC
  typedef logic [REG_ADDR_W-1:0]  reg_addr_t;    // Register file index
  typedef logic [DMEM_ADDR_W-1:0] dmem_index_t;  // Data memory word index

endpackage

// File: src/wb_ctrl_pkg.sv
package wb_ctrl_pkg;

  //////////////////////////////////////////////////
  // Write-back control bundle layout
  //////////////////////////////////////////////////
  // The decode stage packs the write-back controls into one byte
  // that travels down the pipeline untouched until write-back
  localparam int WB_SIG_W = 8;

  typedef logic [WB_SIG_W-1:0] wb_sig_t;

  // Destination register field sits in the upper nibble
  localparam int WB_RD_LSB = 4;
  localparam int WB_RD_W   = 4;

  // Single bit controls in the lower nibble
  localparam int WB_REGWRITE_BIT = 3;  // Commit the selected value to the register file
  localparam int WB_MEMTOREG_BIT = 2;  // Write-back value comes from the data memory
  localparam int WB_HLT_BIT      = 1;  // Halt instruction has reached write-back
  localparam int WB_PCS_BIT      = 0;  // Save-PC instruction writes the next PC

endpackage

// File: src/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

// Data memory of the memory stage
// Reads are combinational so the loaded word is ready for the
// pipeline register in the same cycle the address is presented
module data_memory (
  input  logic                 clk,    // System clock
  input  cpu_types_pkg::word_t addr,   // Byte-free word address, taken from the ALU result
  input  cpu_types_pkg::word_t wdata,  // Store data
  input  logic                 wen,    // Store strobe, sampled on the rising edge
  output cpu_types_pkg::word_t rdata   // Word read at addr
);

  import cpu_types_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  // The memory has no reset, its contents are whatever was stored last
  word_t       mem [DMEM_DEPTH];
  dmem_index_t index;  // Word index into the array

  // Upper address bits alias onto the same 256 words
  assign index = addr[DMEM_ADDR_W-1:0];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[index] <= wdata;  // Store lands at the edge
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////
  // A load in the same cycle as a store to the same word sees the
  // old contents, since the array only changes at the clock edge
  assign rdata = mem[index];

endmodule

`default_nettype wire

// File: src/mem_wb_pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

// Pipeline register between the memory and write-back stages
// Every field advances every cycle, there is no stall or flush
module mem_wb_pipe_reg (
  input  logic                 clk,             // System clock
  input  logic                 rst_n,           // Asynchronous reset, active low
  input  cpu_types_pkg::word_t pc_next_in,      // Next PC from the memory stage
  input  cpu_types_pkg::word_t alu_out_in,      // ALU result from the memory stage
  input  cpu_types_pkg::word_t mem_data_in,     // Word read from data memory
  input  wb_ctrl_pkg::wb_sig_t wb_signals_in,   // Write-back control bundle

  output cpu_types_pkg::word_t pc_next_out,     // Next PC for write-back
  output cpu_types_pkg::word_t alu_out_out,     // ALU result for write-back
  output cpu_types_pkg::word_t mem_data_out,    // Loaded word for write-back
  output wb_ctrl_pkg::wb_sig_t wb_signals_out   // Control bundle for write-back
);

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////
  // The control bundle is held as one vector so the destination,
  // RegWrite, MemtoReg, HLT and PCS fields always move together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Clearing the bundle turns RegWrite and HLT off out of reset
      pc_next_out    <= '0;
      alu_out_out    <= '0;
      mem_data_out   <= '0;
      wb_signals_out <= '0;
    end else begin
      pc_next_out    <= pc_next_in;     // Needed by the save-PC instruction
      alu_out_out    <= alu_out_in;     // Default write-back source
      mem_data_out   <= mem_data_in;    // Load result
      wb_signals_out <= wb_signals_in;  // Controls ride along with their data
    end
  end

endmodule

`default_nettype wire

// File: src/wb_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

// Write-back stage with the register file
// Picks the value to commit, writes it on the clock and serves
// two combinational read ports that see an in-flight write
module wb_reg_file (
  input  logic                      clk,         // System clock
  input  logic                      rst_n,       // Asynchronous reset, active low
  input  cpu_types_pkg::word_t      pc_next,     // Registered next PC
  input  cpu_types_pkg::word_t      alu_out,     // Registered ALU result
  input  cpu_types_pkg::word_t      mem_data,    // Registered load data
  input  wb_ctrl_pkg::wb_sig_t      wb_signals,  // Registered control bundle
  input  cpu_types_pkg::reg_addr_t  rd_addr_1,   // Read port 1 register number
  input  cpu_types_pkg::reg_addr_t  rd_addr_2,   // Read port 2 register number

  output cpu_types_pkg::word_t      rd_data_1,   // Read port 1 data
  output cpu_types_pkg::word_t      rd_data_2,   // Read port 2 data
  output logic                      halt         // Halt has reached write-back
);

  import cpu_types_pkg::*;
  import wb_ctrl_pkg::*;

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  reg_addr_t wr_addr;     // Destination register
  logic      reg_write;   // RegWrite field
  logic      mem_to_reg;  // MemtoReg field
  logic      pcs;         // PCS field
  logic      wr_en;       // Qualified write, never to register zero
  word_t     wr_data;     // Value chosen for write-back

  assign wr_addr    = wb_signals[WB_RD_LSB +: WB_RD_W];
  assign reg_write  = wb_signals[WB_REGWRITE_BIT];
  assign mem_to_reg = wb_signals[WB_MEMTOREG_BIT];
  assign pcs        = wb_signals[WB_PCS_BIT];
  assign halt       = wb_signals[WB_HLT_BIT];  // Already cleared by the stage register on reset

  // Register zero is hardwired to zero so writes to it are dropped
  assign wr_en = reg_write && (wr_addr != '0);

  //////////////////////////////////////////////////
  // Write-back source select
  //////////////////////////////////////////////////
  // Loads win over save-PC, and the ALU result is the fallback
  always_comb begin
    if (mem_to_reg) begin
      wr_data = mem_data;
    end else if (pcs) begin
      wr_data = pc_next;  // Return address for the save-PC instruction
    end else begin
      wr_data = alu_out;
    end
  end

  //////////////////////////////////////////////////
  // Register array
  //////////////////////////////////////////////////
  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // All registers read zero out of reset
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Read ports with bypass
  //////////////////////////////////////////////////
  // A read of the register being written this cycle returns the new
  // value, so decode sees it one cycle before it lands in the array
  assign rd_data_1 = (wr_en && (rd_addr_1 == wr_addr)) ? wr_data : regs[rd_addr_1];
  assign rd_data_2 = (wr_en && (rd_addr_2 == wr_addr)) ? wr_data : regs[rd_addr_2];

endmodule

`default_nettype wire

// File: src/mem_wb_backend.sv
`timescale 1ns/1ns
`default_nettype none

// Back end of the pipeline from the memory stage to write-back
// The execute stage is modelled by the ex_mem_* inputs
module mem_wb_backend (
  input  logic                     clk,                // System clock
  input  logic                     rst_n,              // Asynchronous reset, active low
  input  cpu_types_pkg::word_t     ex_mem_pc_next,     // Next PC from execute
  input  cpu_types_pkg::word_t     ex_mem_alu_out,     // ALU result, also the memory address
  input  cpu_types_pkg::word_t     ex_mem_store_data,  // Data for a store
  input  logic                     ex_mem_mem_write,   // Store strobe
  input  wb_ctrl_pkg::wb_sig_t     ex_mem_wb_signals,  // Write-back control bundle
  input  cpu_types_pkg::reg_addr_t rd_addr_1,          // Register read port 1 address
  input  cpu_types_pkg::reg_addr_t rd_addr_2,          // Register read port 2 address

  output cpu_types_pkg::word_t     rd_data_1,          // Register read port 1 data
  output cpu_types_pkg::word_t     rd_data_2,          // Register read port 2 data
  output logic                     halt                // Processor halted
);

  import cpu_types_pkg::*;
  import wb_ctrl_pkg::*;

  //////////////////////////////////////////////////
  // Stage to stage wires
  //////////////////////////////////////////////////
  word_t   mem_data;           // Combinational load data
  word_t   mem_wb_pc_next;     // Registered next PC
  word_t   mem_wb_alu_out;     // Registered ALU result
  word_t   mem_wb_mem_data;    // Registered load data
  wb_sig_t mem_wb_wb_signals;  // Registered control bundle

  // Memory stage
  data_memory i_dmem (
    .clk   (clk),
    .addr  (ex_mem_alu_out),     // Loads and stores address memory with the ALU result
    .wdata (ex_mem_store_data),
    .wen   (ex_mem_mem_write),
    .rdata (mem_data)
  );

  // Memory to write-back boundary
  mem_wb_pipe_reg i_mem_wb_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_next_in     (ex_mem_pc_next),
    .alu_out_in     (ex_mem_alu_out),
    .mem_data_in    (mem_data),
    .wb_signals_in  (ex_mem_wb_signals),
    .pc_next_out    (mem_wb_pc_next),
    .alu_out_out    (mem_wb_alu_out),
    .mem_data_out   (mem_wb_mem_data),
    .wb_signals_out (mem_wb_wb_signals)
  );

  // Write-back stage and register file
  wb_reg_file i_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_next    (mem_wb_pc_next),
    .alu_out    (mem_wb_alu_out),
    .mem_data   (mem_wb_mem_data),
    .wb_signals (mem_wb_wb_signals),
    .rd_addr_1  (rd_addr_1),
    .rd_addr_2  (rd_addr_2),
    .rd_data_1  (rd_data_1),
    .rd_data_2  (rd_data_2),
    .halt       (halt)
  );

endmodule

`default_nettype wire

// File: test/tb_mem_wb_backend.sv
`timescale 1ns/1ns

module tb_mem_wb_backend;

  import cpu_types_pkg::*;
  import wb_ctrl_pkg::*;

  localparam int    MAX_CYCLES = 5000;  // Watchdog limit, well above the full run
  localparam int    RANDOM_OPS = 300;
  localparam int    MAX_LINES  = 1000;
  localparam string STIM_FILE  = "test/mem_wb_stimulus.txt";

  logic      clk;
  logic      rst_n;
  word_t     ex_mem_pc_next;
  word_t     ex_mem_alu_out;
  word_t     ex_mem_store_data;
  logic      ex_mem_mem_write;
  wb_sig_t   ex_mem_wb_signals;
  reg_addr_t rd_addr_1;
  reg_addr_t rd_addr_2;
  word_t     rd_data_1;
  word_t     rd_data_2;
  logic      halt;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////
  word_t       m_regs [NUM_REGS];    // Register contents after the last edge
  word_t       m_mem  [DMEM_DEPTH];  // Left unknown, like the real memory
  logic        p_wen;                // Write sitting in the pipeline register
  reg_addr_t   p_addr;
  word_t       p_data;
  logic        p_hlt;
  logic [31:0] lfsr;
  int          checks;
  int          value_errors;
  int          other_errors;
  int          lines_run;

  mem_wb_backend uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_mem_pc_next    (ex_mem_pc_next),
    .ex_mem_alu_out    (ex_mem_alu_out),
    .ex_mem_store_data (ex_mem_store_data),
    .ex_mem_mem_write  (ex_mem_mem_write),
    .ex_mem_wb_signals (ex_mem_wb_signals),
    .rd_addr_1         (rd_addr_1),
    .rd_addr_2         (rd_addr_2),
    .rd_data_1         (rd_data_1),
    .rd_data_2         (rd_data_2),
    .halt              (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // Watchdog so a stuck run still ends with a verdict
  initial begin
    for (int i = 0; i < MAX_CYCLES; i++) begin
      @(posedge clk);
    end
    $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);        // One step for every bit taken
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // One pipeline cycle, driven at the falling edge
  //////////////////////////////////////////////////
  task automatic run_cycle(input word_t alu, input word_t pc, input word_t wdata,
                           input logic wen, input wb_sig_t wb, input reg_addr_t ra1,
                           input reg_addr_t ra2, input logic has_exp, input word_t exp_val,
                           input string name);
    word_t       load_val;
    word_t       wb_val;
    word_t       exp_1;
    word_t       exp_2;
    dmem_index_t idx;
    ex_mem_alu_out    = alu;
    ex_mem_pc_next    = pc;
    ex_mem_store_data = wdata;
    ex_mem_mem_write  = wen;
    ex_mem_wb_signals = wb;
    rd_addr_1         = ra1;
    rd_addr_2         = ra2;
    idx      = alu[DMEM_ADDR_W-1:0];  // Upper address bits alias
    load_val = m_mem[idx];            // A load sees the word from before a same cycle store
    if (wen) begin
      m_mem[idx] = wdata;
    end
    if (wb[WB_MEMTOREG_BIT]) begin
      wb_val = load_val;
    end else if (wb[WB_PCS_BIT]) begin
      wb_val = pc;
    end else begin
      wb_val = alu;
    end
    @(posedge clk);
    if (p_wen) begin
      m_regs[p_addr] = p_data;  // Previous cycle's write lands in the array
    end
    p_wen  = wb[WB_REGWRITE_BIT] && (wb[WB_RD_LSB +: WB_RD_W] != '0);
    p_addr = wb[WB_RD_LSB +: WB_RD_W];
    p_data = wb_val;
    p_hlt  = wb[WB_HLT_BIT];
    @(negedge clk);
    // Bypass returns the value in flight to the same register
    exp_1 = (p_wen && (ra1 == p_addr)) ? p_data : m_regs[ra1];
    exp_2 = (p_wen && (ra2 == p_addr)) ? p_data : m_regs[ra2];
    check_word({name, " port 1"}, exp_1, rd_data_1);
    check_word({name, " port 2"}, exp_2, rd_data_2);
    if (has_exp) begin
      check_word({name, " file value"}, exp_val, rd_data_1);
    end
    checks++;
    if (halt !== p_hlt) begin
      value_errors++;
      $display("error %s halt expected %b actual %b", name, p_hlt, halt);
    end
  endtask

  task automatic check_reset_state();
    for (int r = 0; r < NUM_REGS; r++) begin
      run_cycle('0, '0, '0, 1'b0, '0, reg_addr_t'(r), reg_addr_t'(NUM_REGS - 1 - r),
                1'b1, '0, $sformatf("reset reg %0d", r));
    end
  endtask

  task automatic run_directed();
    int        fd;
    int        code;
    int        n;
    int        line_no;
    string     line;
    word_t     alu;
    word_t     pc;
    word_t     wdata;
    word_t     exp_val;
    logic      wen;
    wb_sig_t   wb;
    reg_addr_t ra;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the stimulus file %s", STIM_FILE);
      return;
    end
    line_no = 0;
    while (!$feof(fd) && line_no < MAX_LINES) begin
      code = $fgets(line, fd);
      line_no++;
      if (code > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", alu, pc, wdata, wen, wb, ra, exp_val);
        if (n == 7) begin
          lines_run++;
          run_cycle(alu, pc, wdata, wen, wb, ra, ~ra, 1'b1, exp_val,
                    $sformatf("directed line %0d", line_no));
        end else if (n > 0) begin
          other_errors++;
          $display("Stimulus line %0d could not be parsed", line_no);
        end
      end
    end
    $fclose(fd);
    if (lines_run == 0) begin
      other_errors++;
      $display("No directed stimulus lines were applied");
    end
  endtask

  //////////////////////////////////////////////////
  // Random mix over a filled window of memory
  //////////////////////////////////////////////////
  task automatic run_random();
    logic [31:0] r;
    word_t       addr;
    word_t       data;
    word_t       pc;
    wb_sig_t     wb;
    logic        wen;
    reg_addr_t   ra1;
    reg_addr_t   ra2;
    logic [1:0]  op;
    // Loads stay inside 0x40 to 0x4f, so fill those words first
    for (int k = 0; k < 16; k++) begin
      addr = 16'h0040 + 16'(k);
      run_cycle(addr, '0, {addr[7:0], ~addr[7:0]}, 1'b1, '0, reg_addr_t'(k), reg_addr_t'(~k),
                1'b0, '0, "fill");
    end
    for (int i = 0; i < RANDOM_OPS; i++) begin
      wb = '0;
      take_bits(2, r);
      op = r[1:0];
      take_bits(4, r);
      wb[WB_RD_LSB +: WB_RD_W] = r[3:0];
      take_bits(1, r);
      wb[WB_REGWRITE_BIT] = r[0];
      take_bits(3, r);
      wb[WB_HLT_BIT] = (r[2:0] == 3'b000);  // Halt in about one cycle out of eight
      take_bits(16, r);
      data = r[15:0];
      take_bits(16, r);
      pc = r[15:0];
      take_bits(8, r);
      ra1 = r[3:0];
      ra2 = r[7:4];
      take_bits(12, r);
      addr = {r[11:4], 4'h4, r[3:0]};  // Random upper bits alias onto the window
      wen  = 1'b0;
      case (op)
        2'd1: begin
          wen = 1'b1;                   // Store never writes a register
          wb[WB_REGWRITE_BIT] = 1'b0;
        end
        2'd2: wb[WB_MEMTOREG_BIT] = 1'b1;
        2'd3: wb[WB_PCS_BIT] = 1'b1;
        default: ;
      endcase
      run_cycle((op == 2'd1 || op == 2'd2) ? addr : data, pc, data, wen, wb, ra1, ra2,
                1'b0, '0, $sformatf("random op %0d", i));
    end
  endtask

  initial begin
    rst_n             = 1'b0;
    ex_mem_pc_next    = '0;
    ex_mem_alu_out    = '0;
    ex_mem_store_data = '0;
    ex_mem_mem_write  = 1'b0;
    ex_mem_wb_signals = '0;
    rd_addr_1         = '0;
    rd_addr_2         = '0;
    lfsr              = 32'hf0bc_aadb;
    checks            = 0;
    value_errors      = 0;
    other_errors      = 0;
    lines_run         = 0;
    for (int r = 0; r < NUM_REGS; r++) begin
      m_regs[r] = '0;
    end
    p_wen  = 1'b0;
    p_addr = '0;
    p_data = '0;
    p_hlt  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_reset_state();
    run_directed();
    run_random();
    run_cycle('0, '0, '0, 1'b0, '0, 4'd1, 4'd2, 1'b0, '0, "drain");
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
src/cpu_types_pkg.sv
src/wb_ctrl_pkg.sv
src/data_memory.sv
src/mem_wb_pipe_reg.sv
src/wb_reg_file.sv
src/mem_wb_backend.sv
test/tb_mem_wb_backend.sv

// File: Makefile
# Verilator build and run for the memory to write-back back end

VERILATOR ?= verilator
TOP       ?= tb_mem_wb_backend
RTL_TOP   ?= mem_wb_backend
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/mem_wb_stimulus.txt
# alu_out pc_next store_data mem_write wb_bundle rd_addr expected (all hex)
# bundle is rd<<4 | RegWrite 8 | MemtoReg 4 | HLT 2 | PCS 1, expected is rd_addr after this write
1234 0002 0000 0 18 1 1234
0000 0004 0000 0 00 1 1234
beef 0006 0000 0 28 2 beef
0000 0008 0000 0 00 1 1234
0010 000a cafe 1 00 2 beef
0010 000c 0000 0 3c 3 cafe
0010 000e 2222 1 4c 4 cafe
0310 0010 0000 0 5c 5 2222
7777 0012 0000 0 08 0 0000
0000 0014 0000 0 00 0 0000
0010 0016 0000 0 0c 0 0000
5555 0abc 0000 0 69 6 0abc
0010 0def 0000 0 7d 7 2222
9999 0018 0000 0 10 1 1234
0010 001a 0000 0 25 2 beef
0000 001c 0000 0 02 6 0abc
0000 001e 0000 0 00 7 2222
0001 0020 0000 0 18 1 0001
0002 0022 0000 0 18 1 0002
0000 0024 0000 0 00 1 0002
ffff 0026 0000 0 f8 f ffff
0000 0028 0000 0 00 f ffff
00aa 002a 0000 0 8a 8 00aa
0000 002c 0000 0 00 8 00aa
0000 002e 0000 0 00 3 cafe
0000 0030 0000 0 00 4 cafe
0000 0032 0000 0 00 5 2222
